//--- csr_pkg.sv
package csr_pkg;

    typedef logic [31:0] csr_word_t;
    typedef logic [13:0] csr_num_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;

    // register numbers
    localparam csr_num_t CSR_CRMD   = 14'h0;
    localparam csr_num_t CSR_PRMD   = 14'h1;
    localparam csr_num_t CSR_ECFG   = 14'h4;
    localparam csr_num_t CSR_ESTAT  = 14'h5;
    localparam csr_num_t CSR_ERA    = 14'h6;
    localparam csr_num_t CSR_BADV   = 14'h7;
    localparam csr_num_t CSR_EENTRY = 14'hc;
    localparam csr_num_t CSR_SAVE0  = 14'h30;  // SAVE1.. follow on
    localparam csr_num_t CSR_TID    = 14'h40;
    localparam csr_num_t CSR_TCFG   = 14'h41;
    localparam csr_num_t CSR_TVAL   = 14'h42;
    localparam csr_num_t CSR_TICLR  = 14'h44;

    localparam ecode_t    ECODE_ADE     = 6'h08;
    localparam ecode_t    ECODE_ALE     = 6'h09;
    localparam esubcode_t ESUBCODE_ADEF = 9'h0;  // fetch address error

    // field positions and widths
    localparam int          CRMD_IE_BIT       = 2;
    localparam int          CRMD_DA_BIT       = 3;
    localparam int          EENTRY_VA_LSB     = 6;
    localparam int          IS_WIDTH          = 13;
    localparam logic [12:0] ECFG_LIE_MASK     = 13'h1bff;
    localparam int          INT_TIMER_BIT     = 11;
    localparam int          HW_INT_WIDTH      = 8;
    localparam int          TCFG_EN_BIT       = 0;
    localparam int          TCFG_PERIODIC_BIT = 1;
    localparam int          TICLR_CLR_BIT     = 0;

    // bit-wise write rule shared by every register group
    function automatic csr_word_t wmerge(csr_word_t old, csr_word_t mask,
                                         csr_word_t value);
        return (old & ~mask) | (value & mask);
    endfunction

endpackage

//--- csr_mode.sv
module csr_mode (
    input  logic               clk,
    input  logic               reset,
    input  logic               csr_we,
    input  csr_pkg::csr_num_t  csr_num,
    input  csr_pkg::csr_word_t csr_wmask,
    input  csr_pkg::csr_word_t csr_wvalue,
    input  logic               wb_ex,
    input  logic               ertn_flush,
    input  csr_pkg::csr_word_t wb_pc,
    output logic               crmd_ie,
    output csr_pkg::csr_word_t ex_entry,
    output csr_pkg::csr_word_t ertn_entry,
    output csr_pkg::csr_word_t rvalue_mode
);
    import csr_pkg::*;

    logic [1:0]                crmd_plv;
    logic [1:0]                prmd_pplv;
    logic                      prmd_pie;
    csr_word_t                 era;
    logic [31:EENTRY_VA_LSB]   eentry_va;
    csr_word_t                 crmd_word;
    csr_word_t                 prmd_word;
    csr_word_t                 eentry_word;
    csr_word_t                 crmd_next;
    csr_word_t                 prmd_next;
    csr_word_t                 era_next;
    csr_word_t                 eentry_next;

    always_comb begin
        crmd_word = '0;
        crmd_word[1:0] = crmd_plv;
        crmd_word[CRMD_IE_BIT] = crmd_ie;
        crmd_word[CRMD_DA_BIT] = 1'b1;  // direct address only
    end

    assign prmd_word   = {29'b0, prmd_pie, prmd_pplv};
    assign eentry_word = {eentry_va, {EENTRY_VA_LSB{1'b0}}};

    assign crmd_next   = wmerge(crmd_word, csr_wmask, csr_wvalue);
    assign prmd_next   = wmerge(prmd_word, csr_wmask, csr_wvalue);
    assign era_next    = wmerge(era, csr_wmask, csr_wvalue);
    assign eentry_next = wmerge(eentry_word, csr_wmask, csr_wvalue);

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv  <= '0;
            crmd_ie   <= 1'b0;
            prmd_pplv <= '0;
            prmd_pie  <= 1'b0;
            era       <= '0;
            eentry_va <= '0;
        end else begin
            if (wb_ex) begin
                prmd_pplv <= crmd_plv;  // save mode, enter kernel
                prmd_pie  <= crmd_ie;
                crmd_plv  <= '0;
                crmd_ie   <= 1'b0;
                era       <= wb_pc;
            end else if (ertn_flush) begin
                crmd_plv <= prmd_pplv;
                crmd_ie  <= prmd_pie;
            end else if (csr_we) begin
                case (csr_num)
                    CSR_CRMD: begin
                        crmd_plv <= crmd_next[1:0];
                        crmd_ie  <= crmd_next[CRMD_IE_BIT];
                    end
                    CSR_PRMD: begin
                        prmd_pplv <= prmd_next[1:0];
                        prmd_pie  <= prmd_next[2];
                    end
                    CSR_ERA: era <= era_next;
                    default: ;
                endcase
            end
            // entry address is not touched by exceptions
            if (csr_we && csr_num == CSR_EENTRY)
                eentry_va <= eentry_next[31:EENTRY_VA_LSB];
        end
    end

    assign ex_entry   = eentry_word;
    assign ertn_entry = era;

    always_comb begin
        case (csr_num)  // head of the read chain
            CSR_CRMD:   rvalue_mode = crmd_word;
            CSR_PRMD:   rvalue_mode = prmd_word;
            CSR_ERA:    rvalue_mode = era;
            CSR_EENTRY: rvalue_mode = eentry_word;
            default:    rvalue_mode = '0;
        endcase
    end

endmodule

//--- csr_exc.sv
module csr_exc (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             csr_we,
    input  csr_pkg::csr_num_t                csr_num,
    input  csr_pkg::csr_word_t               csr_wmask,
    input  csr_pkg::csr_word_t               csr_wvalue,
    input  logic                             wb_ex,
    input  csr_pkg::ecode_t                  wb_ecode,
    input  csr_pkg::esubcode_t               wb_esubcode,
    input  csr_pkg::csr_word_t               wb_pc,
    input  csr_pkg::csr_word_t               wb_vaddr,
    input  logic [csr_pkg::HW_INT_WIDTH-1:0] hw_int,
    input  logic                             crmd_ie,
    input  logic                             timer_int,
    input  csr_pkg::csr_word_t               rvalue_mode,
    output logic                             has_int,
    output csr_pkg::csr_word_t               rvalue_exc
);
    import csr_pkg::*;

    logic [IS_WIDTH-1:0]     ecfg_lie;
    logic [1:0]              is_sw;
    logic [HW_INT_WIDTH-1:0] is_hw;
    logic [IS_WIDTH-1:0]     estat_is;
    ecode_t                  estat_ecode;
    esubcode_t               estat_esubcode;
    csr_word_t               badv;
    logic                    addr_err;
    csr_word_t               ecfg_word;
    csr_word_t               estat_word;
    csr_word_t               ecfg_next;
    csr_word_t               estat_next;

    always_comb begin
        estat_is = '0;
        estat_is[1:0] = is_sw;
        estat_is[9:2] = is_hw;
        estat_is[INT_TIMER_BIT] = timer_int;  // flag lives in the timer
    end

    assign ecfg_word  = {19'b0, ecfg_lie};
    assign estat_word = {1'b0, estat_esubcode, estat_ecode, 3'b0, estat_is};
    assign ecfg_next  = wmerge(ecfg_word, csr_wmask, csr_wvalue);
    assign estat_next = wmerge(estat_word, csr_wmask, csr_wvalue);

    assign addr_err = (wb_ecode == ECODE_ALE) || (wb_ecode == ECODE_ADE);

    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg_lie       <= '0;
            is_sw          <= '0;
            is_hw          <= '0;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
            badv           <= '0;
        end else begin
            is_hw <= hw_int;  // sampled every cycle
            if (csr_we && csr_num == CSR_ECFG)
                ecfg_lie <= ecfg_next[IS_WIDTH-1:0] & ECFG_LIE_MASK;
            if (csr_we && csr_num == CSR_ESTAT)
                is_sw <= estat_next[1:0];  // only the software bits
            if (wb_ex) begin
                estat_ecode    <= wb_ecode;
                estat_esubcode <= wb_esubcode;
                if (addr_err)
                    badv <= (wb_ecode == ECODE_ADE && wb_esubcode == ESUBCODE_ADEF) ?
                            wb_pc : wb_vaddr;
            end
        end
    end

    assign has_int = (|(estat_is[11:0] & ecfg_lie[11:0])) & crmd_ie;

    always_comb begin
        rvalue_exc = rvalue_mode;
        case (csr_num)
            CSR_ECFG:  rvalue_exc = rvalue_mode | ecfg_word;
            CSR_ESTAT: rvalue_exc = rvalue_mode | estat_word;
            CSR_BADV:  rvalue_exc = rvalue_mode | badv;
            default:   ;
        endcase
    end

endmodule

//--- csr_timer.sv
module csr_timer #(
    parameter int TIMER_WIDTH = 32
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               csr_we,
    input  csr_pkg::csr_num_t  csr_num,
    input  csr_pkg::csr_word_t csr_wmask,
    input  csr_pkg::csr_word_t csr_wvalue,
    input  csr_pkg::csr_word_t rvalue_exc,
    output logic               timer_int,
    output csr_pkg::csr_word_t rvalue_timer
);
    import csr_pkg::*;

    csr_word_t              tid;
    logic                   tcfg_en;
    logic                   tcfg_periodic;
    logic [TIMER_WIDTH-3:0] tcfg_initval;
    logic [TIMER_WIDTH-1:0] timer_cnt;
    csr_word_t              tid_next;
    csr_word_t              tcfg_word;
    csr_word_t              tcfg_next;
    logic                   tcfg_wr;
    logic                   ticlr_wr;
    logic                   cnt_zero;

    assign tcfg_word = csr_word_t'({tcfg_initval, tcfg_periodic, tcfg_en});
    assign tcfg_next = wmerge(tcfg_word, csr_wmask, csr_wvalue);
    assign tid_next  = wmerge(tid, csr_wmask, csr_wvalue);
    assign tcfg_wr   = csr_we && csr_num == CSR_TCFG;
    assign ticlr_wr  = csr_we && csr_num == CSR_TICLR
                       && csr_wmask[TICLR_CLR_BIT] && csr_wvalue[TICLR_CLR_BIT];
    assign cnt_zero  = (timer_cnt == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            tid           <= '0;
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= '0;
        end else begin
            if (csr_we && csr_num == CSR_TID)
                tid <= tid_next;
            if (tcfg_wr) begin
                tcfg_en       <= tcfg_next[TCFG_EN_BIT];
                tcfg_periodic <= tcfg_next[TCFG_PERIODIC_BIT];
                tcfg_initval  <= tcfg_next[TIMER_WIDTH-1:2];
            end
        end
    end

    // countdown, parks at all ones in one-shot mode
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_cnt <= '1;
        end else if (tcfg_wr && tcfg_next[TCFG_EN_BIT]) begin
            timer_cnt <= {tcfg_next[TIMER_WIDTH-1:2], 2'b00};
        end else if (tcfg_en && timer_cnt != '1) begin
            if (cnt_zero && tcfg_periodic)
                timer_cnt <= {tcfg_initval, 2'b00};
            else
                timer_cnt <= timer_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            timer_int <= 1'b0;
        else if (tcfg_en && cnt_zero)
            timer_int <= 1'b1;  // expiry wins over a clear
        else if (ticlr_wr)
            timer_int <= 1'b0;
    end

    always_comb begin
        rvalue_timer = rvalue_exc;
        case (csr_num)  // TICLR reads as zero
            CSR_TID:  rvalue_timer = rvalue_exc | tid;
            CSR_TCFG: rvalue_timer = rvalue_exc | tcfg_word;
            CSR_TVAL: rvalue_timer = rvalue_exc | csr_word_t'(timer_cnt);
            default:  ;
        endcase
    end

endmodule

//--- csr_save.sv
module csr_save #(
    parameter int NUM_SAVE = 4
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               csr_we,
    input  csr_pkg::csr_num_t  csr_num,
    input  csr_pkg::csr_word_t csr_wmask,
    input  csr_pkg::csr_word_t csr_wvalue,
    input  csr_pkg::csr_word_t rvalue_timer,
    output csr_pkg::csr_word_t csr_rvalue
);
    import csr_pkg::*;

    csr_word_t save_q [NUM_SAVE];
    csr_word_t save_word;

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_SAVE; i++) begin
            if (reset)
                save_q[i] <= '0;
            else if (csr_we && csr_num == CSR_SAVE0 + csr_num_t'(i))
                save_q[i] <= wmerge(save_q[i], csr_wmask, csr_wvalue);
        end
    end

    always_comb begin
        save_word = '0;
        for (int i = 0; i < NUM_SAVE; i++) begin
            if (csr_num == CSR_SAVE0 + csr_num_t'(i))
                save_word = save_q[i];
        end
    end

    assign csr_rvalue = rvalue_timer | save_word;  // end of the read chain

endmodule

//--- csr_top.sv
module csr_top #(
    parameter int TIMER_WIDTH = 32,
    parameter int NUM_SAVE    = 4
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             csr_we,
    input  csr_pkg::csr_num_t                csr_num,
    input  csr_pkg::csr_word_t               csr_wmask,
    input  csr_pkg::csr_word_t               csr_wvalue,
    output csr_pkg::csr_word_t               csr_rvalue,
    input  logic                             wb_ex,
    input  csr_pkg::ecode_t                  wb_ecode,
    input  csr_pkg::esubcode_t               wb_esubcode,
    input  csr_pkg::csr_word_t               wb_pc,
    input  csr_pkg::csr_word_t               wb_vaddr,
    input  logic                             ertn_flush,
    input  logic [csr_pkg::HW_INT_WIDTH-1:0] hw_int,
    output csr_pkg::csr_word_t               ex_entry,
    output csr_pkg::csr_word_t               ertn_entry,
    output logic                             has_int
);
    import csr_pkg::*;

    logic      crmd_ie;
    logic      timer_int;
    csr_word_t rvalue_mode;
    csr_word_t rvalue_exc;
    csr_word_t rvalue_timer;

    csr_mode csr_mode_inst (
        .clk, .reset, .csr_we, .csr_num, .csr_wmask, .csr_wvalue,
        .wb_ex, .ertn_flush, .wb_pc,
        .crmd_ie, .ex_entry, .ertn_entry, .rvalue_mode
    );

    csr_exc csr_exc_inst (
        .clk, .reset, .csr_we, .csr_num, .csr_wmask, .csr_wvalue,
        .wb_ex, .wb_ecode, .wb_esubcode, .wb_pc, .wb_vaddr, .hw_int,
        .crmd_ie, .timer_int, .rvalue_mode,
        .has_int, .rvalue_exc
    );

    csr_timer #(.TIMER_WIDTH(TIMER_WIDTH)) csr_timer_inst (
        .clk, .reset, .csr_we, .csr_num, .csr_wmask, .csr_wvalue,
        .rvalue_exc, .timer_int, .rvalue_timer
    );

    csr_save #(.NUM_SAVE(NUM_SAVE)) csr_save_inst (
        .clk, .reset, .csr_we, .csr_num, .csr_wmask, .csr_wvalue,
        .rvalue_timer, .csr_rvalue
    );

endmodule

//--- csr_tb_assertions.sv
module csr_tb_assertions (
    input logic        clk,
    input logic        reset,
    input logic        has_int,
    input logic        crmd_ie,
    input logic        wb_ex,
    input logic        ertn_flush,
    input logic [31:0] ex_entry,
    input logic [31:0] ertn_entry
);
    int fails = 0;

    int_needs_ie: assert property (@(posedge clk) disable iff (reset) has_int |-> crmd_ie)
        else begin
            fails = fails + 1;
            $error("has_int raised while CRMD IE is clear");
        end

    // entry address is 64-byte aligned
    entry_aligned: assert property (@(posedge clk) disable iff (reset) ex_entry[5:0] == 6'b0)
        else begin
            fails = fails + 1;
            $error("ex_entry low bits not zero");
        end

    era_kept: assert property (@(posedge clk) disable iff (reset)
                               (ertn_flush && !wb_ex) |=> $stable(ertn_entry))
        else begin
            fails = fails + 1;
            $error("ertn_entry changed across ertn_flush");
        end

endmodule

bind csr_top csr_tb_assertions csr_tb_assertions_inst (
    .clk, .reset, .has_int, .crmd_ie, .wb_ex, .ertn_flush, .ex_entry, .ertn_entry
);

//--- csr_tb.sv
module csr_tb;
    import csr_pkg::*;

    logic      clk;
    logic      reset;
    logic      csr_we;
    csr_num_t  csr_num;
    csr_word_t csr_wmask;
    csr_word_t csr_wvalue;
    csr_word_t csr_rvalue;
    logic      wb_ex;
    ecode_t    wb_ecode;
    esubcode_t wb_esubcode;
    csr_word_t wb_pc;
    csr_word_t wb_vaddr;
    logic      ertn_flush;
    logic [HW_INT_WIDTH-1:0] hw_int;
    csr_word_t ex_entry;
    csr_word_t ertn_entry;
    logic      has_int;

    // pending check for the compare process
    logic      chk_en;
    logic [1:0] chk_sel;
    csr_word_t chk_exp;
    csr_word_t chk_mask;
    string     chk_name;
    int        value_errs;
    int        main_errs;
    int        total;

    csr_num_t  acc_num [9];
    csr_word_t acc_bits [9];
    csr_word_t acc_shadow [9];
    csr_word_t rnd;
    csr_word_t mask;
    csr_word_t value;
    csr_word_t pc;
    csr_word_t vaddr;
    csr_word_t badv_shadow;
    csr_word_t tcount;
    ecode_t    ecode;
    esubcode_t sub;
    logic [1:0] plv;
    logic      ie;
    logic [1:0] sw;
    logic [12:0] lie;
    logic [7:0] hw;
    logic [7:0] iv;

    csr_top csr_top_inst (.*);

    always #5 clk = ~clk;

    function automatic csr_word_t masked_merge(csr_word_t old, csr_word_t m, csr_word_t v);
        return (old & ~m) | (v & m);
    endfunction

    function automatic csr_word_t expected_badv(csr_word_t old, ecode_t ec, esubcode_t sc,
                                               csr_word_t epc, csr_word_t va);
        if (ec == ECODE_ADE && sc == ESUBCODE_ADEF)
            return epc;  // fetch error reports the pc
        if (ec == ECODE_ADE || ec == ECODE_ALE)
            return va;
        return old;
    endfunction

    function automatic logic expected_has_int(logic [7:0] h, logic [1:0] s, logic [12:0] l,
                                              logic e);
        logic [11:0] pending;
        pending = {2'b00, h, s};  // timer bit held low here
        return e & (|(pending & l[11:0]));
    endfunction

    task automatic clear_pulses();
        csr_we     <= 1'b0;
        wb_ex      <= 1'b0;
        ertn_flush <= 1'b0;
        chk_en     <= 1'b0;
    endtask

    task automatic write_csr(input csr_num_t num, input csr_word_t m, input csr_word_t v);
        @(posedge clk);
        clear_pulses();
        csr_we     <= 1'b1;
        csr_num    <= num;
        csr_wmask  <= m;
        csr_wvalue <= v;
    endtask

    // sel 0 rvalue, 1 ex_entry, 2 ertn_entry, 3 has_int
    task automatic request_check(input string name, input logic [1:0] sel, input csr_num_t num,
                                 input csr_word_t exp, input csr_word_t m);
        @(posedge clk);
        clear_pulses();
        csr_num  <= num;
        chk_en   <= 1'b1;
        chk_sel  <= sel;
        chk_exp  <= exp;
        chk_mask <= m;
        chk_name <= name;
    endtask

    task automatic raise_exception(input ecode_t ec, input esubcode_t sc, input csr_word_t epc,
                                   input csr_word_t va);
        @(posedge clk);
        clear_pulses();
        wb_ex       <= 1'b1;
        wb_ecode    <= ec;
        wb_esubcode <= sc;
        wb_pc       <= epc;
        wb_vaddr    <= va;
    endtask

    task automatic pulse_ertn();
        @(posedge clk);
        clear_pulses();
        ertn_flush <= 1'b1;
        csr_we     <= 1'b1;  // ERA write that the ertn overrides
        csr_num    <= CSR_ERA;
        csr_wmask  <= '1;
        csr_wvalue <= ~wb_pc;
    endtask

    // counts cycles from the next edge until IS bit 11 reads 1
    task automatic wait_timer_int(input string name, input csr_word_t expected);
        csr_word_t n;
        n = 32'd0;
        @(posedge clk);
        clear_pulses();
        csr_num <= CSR_ESTAT;
        @(negedge clk);
        while (!csr_rvalue[INT_TIMER_BIT] && n <= expected + 32'd8) begin
            @(negedge clk);
            n = n + 32'd1;
        end
        if (!csr_rvalue[INT_TIMER_BIT]) begin
            main_errs++;
            $display("timeout: %s, timer interrupt not seen after %0d cycles", name, n);
        end else if (n != expected) begin
            main_errs++;
            $display("ERR %s: expected %0d cycles, actual %0d", name, expected, n);
        end
    endtask

    always @(negedge clk) begin
        csr_word_t obs;
        case (chk_sel)
            2'd0:    obs = csr_rvalue;
            2'd1:    obs = ex_entry;
            2'd2:    obs = ertn_entry;
            default: obs = {31'b0, has_int};
        endcase
        if (chk_en && (obs & chk_mask) != chk_exp) begin
            value_errs++;
            $display("ERR %s: expected %h, actual %h", chk_name, chk_exp, obs & chk_mask);
        end
    end

    initial begin
        rnd = $urandom(32'hd99b_a41d);  // seeds the generator
        clk = 1'b0;
        reset = 1'b1;
        csr_we = 1'b0;
        csr_num = '0;
        csr_wmask = '0;
        csr_wvalue = '0;
        wb_ex = 1'b0;
        wb_ecode = '0;
        wb_esubcode = '0;
        wb_pc = '0;
        wb_vaddr = '0;
        ertn_flush = 1'b0;
        hw_int = '0;
        chk_en = 1'b0;
        chk_sel = 2'd0;
        chk_exp = '0;
        chk_mask = '0;
        value_errs = 0;
        main_errs = 0;
        badv_shadow = '0;
        acc_num = '{CSR_SAVE0, CSR_SAVE0 + 14'd1, CSR_SAVE0 + 14'd2, CSR_SAVE0 + 14'd3,
                    CSR_ERA, CSR_EENTRY, CSR_TID, CSR_ECFG, CSR_PRMD};
        acc_bits = '{32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff,
                     32'hffff_ffff, 32'hffff_ffc0, 32'hffff_ffff, 32'h0000_1bff, 32'h7};
        acc_shadow = '{default: '0};
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        request_check("reset crmd", 2'd0, CSR_CRMD, 32'h8, '1);
        request_check("reset estat", 2'd0, CSR_ESTAT, '0, '1);
        request_check("reset tval", 2'd0, CSR_TVAL, 32'hffff_ffff, '1);
        request_check("reset tcfg", 2'd0, CSR_TCFG, '0, '1);
        request_check("reset badv", 2'd0, CSR_BADV, '0, '1);
        request_check("reset has_int", 2'd3, CSR_CRMD, '0, '1);
        request_check("unknown number", 2'd0, 14'h3, '0, '1);

        for (int round = 0; round < 4; round++) begin
            for (int r = 0; r < 9; r++) begin
                mask = $urandom;
                value = $urandom;
                write_csr(acc_num[r], mask, value);
                acc_shadow[r] = masked_merge(acc_shadow[r], mask, value) & acc_bits[r];
                request_check("masked access", 2'd0, acc_num[r], acc_shadow[r], '1);
            end
        end

        for (int i = 0; i < 9; i++) begin
            rnd = $urandom;
            plv = rnd[1:0];
            ie = rnd[2];
            write_csr(CSR_CRMD, 32'h7, {29'b0, ie, plv});
            pc = $urandom;
            vaddr = $urandom;
            rnd = $urandom;
            sub = rnd[8:0];
            case (i % 3)
                0: ecode = ECODE_ALE;
                1: begin
                    ecode = ECODE_ADE;
                    sub = ESUBCODE_ADEF;
                end
                default: ecode = {1'b1, rnd[13:9]};  // never ADE or ALE
            endcase
            raise_exception(ecode, sub, pc, vaddr);
            badv_shadow = expected_badv(badv_shadow, ecode, sub, pc, vaddr);
            request_check("crmd on entry", 2'd0, CSR_CRMD, 32'h8, '1);
            request_check("prmd save", 2'd0, CSR_PRMD, {29'b0, ie, plv}, '1);
            request_check("era capture", 2'd0, CSR_ERA, pc, '1);
            request_check("estat codes", 2'd0, CSR_ESTAT, {1'b0, sub, ecode, 16'b0},
                          32'h7fff_0000);
            request_check("badv", 2'd0, CSR_BADV, badv_shadow, '1);
            request_check("ex_entry", 2'd1, CSR_EENTRY, acc_shadow[5], '1);
            pulse_ertn();
            request_check("crmd on ertn", 2'd0, CSR_CRMD, {28'b0, 1'b1, ie, plv}, '1);
            request_check("ertn_entry", 2'd2, CSR_ERA, pc, '1);
        end

        // the one-shot TVAL check falls in the load cycle
        rnd = $urandom;
        iv = 8'd2 + {5'b0, rnd[2:0]};
        tcount = {22'b0, iv, 2'b00};
        write_csr(CSR_TCFG, '1, {22'b0, iv, 2'b01});
        request_check("one-shot load", 2'd0, CSR_TVAL, tcount, '1);
        wait_timer_int("one-shot expiry", tcount);
        request_check("one-shot stop", 2'd0, CSR_TVAL, 32'hffff_ffff, '1);
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        request_check("ticlr clear", 2'd0, CSR_ESTAT, '0, 32'h800);

        rnd = $urandom;
        iv = 8'd2 + {5'b0, rnd[2:0]};
        tcount = {22'b0, iv, 2'b00};
        write_csr(CSR_TCFG, '1, {22'b0, iv, 2'b11});
        request_check("periodic load", 2'd0, CSR_TVAL, tcount, '1);
        wait_timer_int("periodic expiry", tcount);
        request_check("periodic reload", 2'd0, CSR_TVAL, tcount - 32'd1, '1);
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        request_check("ticlr clear", 2'd0, CSR_ESTAT, '0, 32'h800);
        write_csr(CSR_TCFG, '1, '0);

        for (int i = 0; i < 16; i++) begin
            rnd = $urandom;
            lie = rnd[12:0] & ECFG_LIE_MASK;
            sw = rnd[14:13];
            ie = rnd[15];
            hw = rnd[23:16];
            write_csr(CSR_ECFG, '1, {19'b0, lie});
            hw_int <= hw;
            write_csr(CSR_ESTAT, 32'h3, {30'b0, sw});
            write_csr(CSR_CRMD, 32'h4, {29'b0, ie, 2'b00});
            request_check("has_int", 2'd3, CSR_ESTAT,
                          {31'b0, expected_has_int(hw, sw, lie, ie)}, 32'h1);
        end

        @(posedge clk);
        clear_pulses();
        @(posedge clk);
        total = value_errs + main_errs + csr_top_inst.csr_tb_assertions_inst.fails;
        $display("value errors: %0d, timing errors: %0d, assertion failures: %0d",
                 value_errs, main_errs, csr_top_inst.csr_tb_assertions_inst.fails);
        if (total == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

//--- list.f
csr_pkg.sv
csr_mode.sv
csr_exc.sv
csr_timer.sv
csr_save.sv
csr_top.sv
csr_tb_assertions.sv
csr_tb.sv

//--- run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --assert -f list.f --top-module csr_tb -o csr_sim || exit 1
./obj_dir/csr_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q "Errors found" sim.log && exit 1
grep -q "No errors" sim.log || exit 1
exit 0
